// File: jogo_memoria.f
jogo_memoria_pkg.sv
contador_m.sv
sync_rom_16x4.sv
fluxo_dados.sv
unidade_controle.sv
jogo_memoria.sv
tb_jogo_memoria.sv

// File: tb_jogo_memoria.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jogo_memoria;

    import jogo_memoria_pkg::*;

    localparam int display_ciclos = 8;
    localparam int timeout_ciclos = 40;
    localparam int limite_ciclos  = 400;

    // how the current game is meant to end
    localparam int modo_correto = 0;
    localparam int modo_erro    = 1;
    localparam int modo_espera  = 2;

    logic              clock = 1'b0;
    logic              rst;
    logic              iniciar;
    logic              seleciona_memoria;
    logic [data_w-1:0] botoes;
    logic [data_w-1:0] leds;
    logic              pronto;
    logic              ganhou;
    logic              perdeu;
    logic              timeout;
    estado_t           db_estado;
    logic [addr_w-1:0] db_contagem;
    logic [addr_w-1:0] db_limite;
    logic [data_w-1:0] db_memoria;
    logic [data_w-1:0] db_jogada;

    int                erros = 0;
    int                timeouts = 0;
    logic              parado = 1'b0;
    int                modo = modo_correto;
    logic              tabela_tb = 1'b0;
    logic [data_w-1:0] jogada_errada = '0;
    logic [31:0]       semente = 32'h3a8a_0fdd;

    // reference state kept by the testbench
    int                rodada_tb = 0;
    int                indice_mostra = 0;
    int                posicao_tb = 0;
    int                ciclos_espera = 0;
    logic              em_mostra;
    logic              em_jogada;
    int                contagem_esperada;
    logic [data_w-1:0] leds_esperado;
    logic [data_w-1:0] memoria_esperada;

    jogo_memoria #(
        .DISPLAY_CYCLES (display_ciclos),
        .TIMEOUT_CYCLES (timeout_ciclos)
    ) dut (
        .clock             (clock),
        .rst               (rst),
        .iniciar           (iniciar),
        .seleciona_memoria (seleciona_memoria),
        .botoes            (botoes),
        .leds              (leds),
        .pronto            (pronto),
        .ganhou            (ganhou),
        .perdeu            (perdeu),
        .timeout           (timeout),
        .db_estado         (db_estado),
        .db_contagem       (db_contagem),
        .db_limite         (db_limite),
        .db_memoria        (db_memoria),
        .db_jogada         (db_jogada)
    );

    always #50 clock = ~clock;

    // table 0 lights bit i mod 4, table 1 lights bit 3i mod 4
    function automatic logic [data_w-1:0] padrao(input logic tabela, input int indice);
        int bit_aceso;
        if (tabela) begin
            bit_aceso = (3 * indice) % 4;
        end else begin
            bit_aceso = indice % 4;
        end
        return data_w'(1) << bit_aceso;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------------
    // reference tracking of rounds, display entries and waiting time
    // ------------------------------------------------------------------

    always @(posedge clock) begin
        if (rst || db_estado == preparacao) begin
            rodada_tb <= 0;
        end else if (db_estado == proxima_rodada) begin
            rodada_tb <= rodada_tb + 1;
        end
    end

    always @(posedge clock) begin
        if (rst || db_estado == preparacao || db_estado == proxima_rodada) begin
            indice_mostra <= 0;
        end else if (db_estado == proximo_mostra) begin
            indice_mostra <= indice_mostra + 1;
        end
    end

    // press position within the player phase
    always @(posedge clock) begin
        if (rst || em_mostra || db_estado == preparacao) begin
            posicao_tb <= 0;
        end else if (db_estado == proxima_jogada) begin
            posicao_tb <= posicao_tb + 1;
        end
    end

    always @(posedge clock) begin
        if (rst || db_estado != espera_jogada) begin
            ciclos_espera <= 0;
        end else begin
            ciclos_espera <= ciclos_espera + 1;
        end
    end

    assign em_mostra = db_estado inside {mostra, mostra_intervalo, proximo_mostra};
    assign em_jogada = db_estado inside {espera_jogada, registra, comparacao, proxima_jogada};
    assign contagem_esperada = em_mostra ? indice_mostra : posicao_tb;

    always_comb begin
        leds_esperado    = padrao(tabela_tb, indice_mostra);
        memoria_esperada = padrao(tabela_tb, posicao_tb);
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_ocioso: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == inicial) |-> (!pronto && !ganhou && !perdeu && !timeout && leds == '0)
    ) else begin
        erros++;
        $display("FAILED %0t: outputs not idle before the first start", $time);
    end

    a_leds_mostra: assert property (
        @(posedge clock) disable iff (rst)
        (em_mostra && leds != '0) |-> (leds == leds_esperado && indice_mostra <= rodada_tb)
    ) else begin
        erros++;
        $display("FAILED %0t: leds %b on display entry %0d of round %0d, expected %b",
                 $time, $sampled(leds), $sampled(indice_mostra), $sampled(rodada_tb),
                 $sampled(leds_esperado));
    end

    // every entry up to the round limit shown before the player phase
    a_mostra_completa: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == espera_jogada && $past(db_estado) == mostra_intervalo)
            |-> (indice_mostra == rodada_tb)
    ) else begin
        erros++;
        $display("FAILED %0t: player phase after %0d entries in round %0d",
                 $time, $sampled(indice_mostra) + 1, $sampled(rodada_tb));
    end

    a_contagem: assert property (
        @(posedge clock) disable iff (rst)
        (em_mostra || em_jogada) |-> (db_contagem == addr_w'(contagem_esperada))
    ) else begin
        erros++;
        $display("FAILED %0t: db_contagem %0d, expected %0d",
                 $time, $sampled(db_contagem), $sampled(contagem_esperada));
    end

    a_limite: assert property (
        @(posedge clock) disable iff (rst)
        db_limite == addr_w'(rodada_tb)
    ) else begin
        erros++;
        $display("FAILED %0t: db_limite %0d, expected %0d",
                 $time, $sampled(db_limite), $sampled(rodada_tb));
    end

    a_memoria: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == comparacao) |-> (db_memoria == memoria_esperada)
    ) else begin
        erros++;
        $display("FAILED %0t: db_memoria %b at press %0d, expected %b",
                 $time, $sampled(db_memoria), $sampled(posicao_tb),
                 $sampled(memoria_esperada));
    end

    a_ganhou: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == fim_ganhou) |-> (pronto && ganhou && !perdeu && !timeout &&
                                       modo == modo_correto && rodada_tb == n_rodadas - 1)
    ) else begin
        erros++;
        $display("FAILED %0t: wrong win, round %0d", $time, $sampled(rodada_tb));
    end

    a_perdeu_erro: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == fim_perdeu && modo == modo_erro)
            |-> (pronto && perdeu && !ganhou && !timeout && db_jogada == jogada_errada)
    ) else begin
        erros++;
        $display("FAILED %0t: loss after wrong press, db_jogada %b expected %b",
                 $time, $sampled(db_jogada), $sampled(jogada_errada));
    end

    a_perdeu_espera: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == fim_perdeu && modo == modo_espera)
            |-> (pronto && perdeu && !ganhou && timeout)
    ) else begin
        erros++;
        $display("FAILED %0t: loss by timeout with wrong result outputs", $time);
    end

    a_sem_derrota: assert property (
        @(posedge clock) disable iff (rst)
        (db_estado == fim_perdeu) |-> (modo != modo_correto)
    ) else begin
        erros++;
        $display("FAILED %0t: game lost although every press was right", $time);
    end

    a_fim_mantido: assert property (
        @(posedge clock) disable iff (rst)
        (pronto && !iniciar) |=> (pronto && $stable(ganhou) && $stable(perdeu) &&
                                  $stable(timeout))
    ) else begin
        erros++;
        $display("FAILED %0t: end state outputs changed without iniciar", $time);
    end

    a_timeout_prazo: assert property (
        @(posedge clock) disable iff (rst)
        $rose(timeout) |-> (ciclos_espera == timeout_ciclos)
    ) else begin
        erros++;
        $display("FAILED %0t: timeout after %0d waiting cycles, expected %0d",
                 $time, $sampled(ciclos_espera), timeout_ciclos);
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    task automatic aguarda_ciclos(input int n);
        repeat (n) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic espera_estado(input estado_t alvo, input int limite);
        int ciclos;
        ciclos = 0;
        while (db_estado != alvo && ciclos < limite) begin
            @(posedge clock);
            #10;
            ciclos++;
        end
        if (db_estado != alvo) begin
            $display("timeout at %0t ns: state %s not reached within %0d cycles",
                     $time, alvo.name(), limite);
            timeouts++;
            parado = 1'b1;
        end
    endtask

    task automatic espera_pronto(input int limite);
        int ciclos;
        ciclos = 0;
        while (!pronto && ciclos < limite) begin
            @(posedge clock);
            #10;
            ciclos++;
        end
        if (!pronto) begin
            $display("timeout at %0t ns: game did not end within %0d cycles", $time, limite);
            timeouts++;
            parado = 1'b1;
        end
    endtask

    // press for two cycles, release for two
    task automatic aperta_botoes(input logic [data_w-1:0] valor);
        botoes = valor;
        aguarda_ciclos(2);
        botoes = '0;
        aguarda_ciclos(2);
    endtask

    task automatic comeca_jogo(input logic tabela, input int modo_jogo);
        seleciona_memoria = tabela;
        iniciar = 1'b1;
        aguarda_ciclos(1);
        iniciar = 1'b0;
        // table must stay latched from here on
        seleciona_memoria = 1'b0;
        modo = modo_jogo;
        tabela_tb = tabela;
    endtask

    task automatic joga_partida(input logic tabela, input int modo_jogo,
                                input int rodada_erro, input int posicao_erro);
        int                r;
        int                p;
        logic              encerrou;
        logic [data_w-1:0] certo;
        encerrou = 1'b0;
        comeca_jogo(tabela, modo_jogo);
        r = 0;
        while (r < n_rodadas && !encerrou && !parado) begin
            p = 0;
            while (p <= r && !encerrou && !parado) begin
                espera_estado(espera_jogada, limite_ciclos);
                certo = padrao(tabela, p);
                if (!parado) begin
                    if (modo_jogo == modo_espera) begin
                        encerrou = 1'b1;
                    end else if (modo_jogo == modo_erro && r == rodada_erro &&
                                 p == posicao_erro) begin
                        jogada_errada = {certo[data_w-2:0], certo[data_w-1]};
                        aperta_botoes(jogada_errada);
                        encerrou = 1'b1;
                    end else begin
                        aperta_botoes(certo);
                    end
                end
                p++;
            end
            r++;
        end
        if (!parado) begin
            espera_pronto(limite_ciclos);
        end
    endtask

    // ------------------------------------------------------------------
    // scenarios
    // ------------------------------------------------------------------

    initial begin
        int rodada_erro;
        int posicao_erro;
        rst = 1'b1;
        iniciar = 1'b0;
        seleciona_memoria = 1'b0;
        botoes = '0;
        repeat (5) @(posedge clock);
        #10;
        rst = 1'b0;
        aguarda_ciclos(4);

        semente = xorshift32(semente);
        rodada_erro = int'(semente % 32'(n_rodadas));
        semente = xorshift32(semente);
        posicao_erro = int'(semente % 32'(rodada_erro + 1));

        // full correct game on table 0
        joga_partida(1'b0, modo_correto, 0, 0);
        if (!parado) begin
            aguarda_ciclos(3);
            $display("wrong press planned at round %0d, position %0d",
                     rodada_erro, posicao_erro);
            joga_partida(1'b0, modo_erro, rodada_erro, posicao_erro);
        end
        // nobody presses, end state held for a while
        if (!parado) begin
            aguarda_ciclos(3);
            joga_partida(1'b0, modo_espera, 0, 0);
        end
        if (!parado) begin
            aguarda_ciclos(6);
            joga_partida(1'b1, modo_correto, 0, 0);
        end
        aguarda_ciclos(3);

        $display("assertion errors: %0d, wait timeouts: %0d", erros, timeouts);
        if (erros == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: jogo_memoria.sv
`timescale 1ns/1ps
`default_nettype none

module jogo_memoria #(
    parameter int DISPLAY_CYCLES = 1000,
    parameter int TIMEOUT_CYCLES = 4000
) (
    input  wire                                 clock,
    input  wire                                 rst,
    input  wire                                 iniciar,
    input  wire                                 seleciona_memoria,
    input  wire  [jogo_memoria_pkg::data_w-1:0] botoes,
    output logic [jogo_memoria_pkg::data_w-1:0] leds,
    output logic                                pronto,
    output logic                                ganhou,
    output logic                                perdeu,
    output logic                                timeout,
    output jogo_memoria_pkg::estado_t           db_estado,
    output logic [jogo_memoria_pkg::addr_w-1:0] db_contagem,
    output logic [jogo_memoria_pkg::addr_w-1:0] db_limite,
    output logic [jogo_memoria_pkg::data_w-1:0] db_memoria,
    output logic [jogo_memoria_pkg::data_w-1:0] db_jogada
);

    import jogo_memoria_pkg::*;

    // control unit to datapath
    logic          zera_e, conta_e, zera_l, conta_l, zera_m, conta_m;
    logic          conta_t, zera_r, registra_r, seleciona_memoria_r;
    seletor_leds_t seletor;

    // datapath status back to the control unit
    logic          fim_e, fim_l, fim_m, meio_m, jogada_feita;
    logic          botoes_igual_memoria, endereco_igual_limite;

    fluxo_dados #(
        .DISPLAY_CYCLES (DISPLAY_CYCLES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) fd (.*);

    unidade_controle uc (.*);

endmodule

`default_nettype wire

// File: unidade_controle.sv
`timescale 1ns/1ps
`default_nettype none

module unidade_controle (
    input  wire                             clock,
    input  wire                             rst,
    input  wire                             iniciar,
    input  wire                             seleciona_memoria,
    input  wire                             fim_e,
    input  wire                             fim_l,
    input  wire                             fim_m,
    input  wire                             meio_m,
    input  wire                             jogada_feita,
    input  wire                             botoes_igual_memoria,
    input  wire                             endereco_igual_limite,
    input  wire                             timeout,
    output logic                            zera_e,
    output logic                            conta_e,
    output logic                            zera_l,
    output logic                            conta_l,
    output logic                            zera_m,
    output logic                            conta_m,
    output logic                            conta_t,
    output logic                            zera_r,
    output logic                            registra_r,
    output logic                            seleciona_memoria_r,
    output jogo_memoria_pkg::seletor_leds_t seletor,
    output logic                            pronto,
    output logic                            ganhou,
    output logic                            perdeu,
    output jogo_memoria_pkg::estado_t       db_estado
);

    import jogo_memoria_pkg::*;

    estado_t           estado;
    estado_t           proximo;
    logic              partida;

    // a new game may start from idle or from either end state
    assign partida = iniciar &&
                     (estado == inicial || estado == fim_ganhou || estado == fim_perdeu);

    always_ff @(posedge clock) begin
        if (rst) begin
            estado <= inicial;
        end else begin
            estado <= proximo;
        end
    end

    // table choice taken with the start request
    always_ff @(posedge clock) begin
        if (rst) begin
            seleciona_memoria_r <= 1'b0;
        end else if (partida) begin
            seleciona_memoria_r <= seleciona_memoria;
        end
    end

    // ----------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------

    always_comb begin
        proximo = estado;
        case (estado)
            inicial, fim_ganhou, fim_perdeu: begin
                if (partida) begin
                    proximo = preparacao;
                end
            end
            preparacao:       proximo = mostra;
            mostra:           if (meio_m) proximo = mostra_intervalo;
            mostra_intervalo: begin
                if (fim_m) begin
                    proximo = endereco_igual_limite ? espera_jogada : proximo_mostra;
                end
            end
            proximo_mostra:   proximo = mostra;
            espera_jogada: begin
                if (timeout) begin
                    proximo = fim_perdeu;
                end else if (jogada_feita) begin
                    proximo = registra;
                end
            end
            registra:         proximo = comparacao;
            comparacao: begin
                if (!botoes_igual_memoria) begin
                    proximo = fim_perdeu;
                end else if (!endereco_igual_limite) begin
                    proximo = proxima_jogada;
                end else if (fim_l) begin
                    proximo = fim_ganhou;
                end else begin
                    proximo = proxima_rodada;
                end
            end
            proxima_jogada:   proximo = espera_jogada;
            proxima_rodada:   proximo = mostra;
            default:          proximo = inicial;
        endcase
    end

    // ----------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------

    always_comb begin
        zera_e     = 1'b0;
        conta_e    = 1'b0;
        zera_l     = 1'b0;
        conta_l    = 1'b0;
        zera_m     = 1'b0;
        conta_m    = 1'b0;
        conta_t    = 1'b0;
        zera_r     = 1'b0;
        registra_r = 1'b0;
        seletor    = leds_apagados;
        pronto     = 1'b0;
        ganhou     = 1'b0;
        perdeu     = 1'b0;
        case (estado)
            preparacao: begin
                zera_e = 1'b1;
                zera_l = 1'b1;
                zera_m = 1'b1;
                zera_r = 1'b1;
            end
            mostra: begin
                conta_m = 1'b1;
                seletor = leds_memoria;
            end
            mostra_intervalo: begin
                conta_m = 1'b1;
                // last entry done, address back to 0 for the player
                zera_e  = fim_m && endereco_igual_limite;
            end
            proximo_mostra: begin
                conta_e = 1'b1;
                zera_m  = 1'b1;
            end
            espera_jogada: begin
                conta_t = 1'b1;
                seletor = leds_botoes;
            end
            registra: begin
                registra_r = 1'b1;
                seletor    = leds_botoes;
            end
            comparacao:     seletor = leds_botoes;
            proxima_jogada: begin
                conta_e = 1'b1;
                seletor = leds_botoes;
            end
            proxima_rodada: begin
                conta_l = 1'b1;
                zera_e  = 1'b1;
                zera_m  = 1'b1;
            end
            fim_ganhou: begin
                pronto = 1'b1;
                ganhou = 1'b1;
            end
            fim_perdeu: begin
                pronto = 1'b1;
                perdeu = 1'b1;
            end
            default: ;
        endcase
    end

    assign db_estado = estado;

    a_resultado_unico: assert property (
        @(posedge clock) disable iff (rst)
        !(ganhou && perdeu)
    ) else $error("unidade_controle: ganhou and perdeu both high");

    a_estado_legal: assert property (
        @(posedge clock) disable iff (rst)
        estado inside {inicial, preparacao, mostra, mostra_intervalo, proximo_mostra,
                       espera_jogada, registra, comparacao, proxima_jogada,
                       proxima_rodada, fim_ganhou, fim_perdeu}
    ) else $error("unidade_controle: illegal state");

    // the address never runs past the round limit
    a_endereco_no_limite: assert property (
        @(posedge clock) disable iff (rst)
        fim_e |-> fim_l
    ) else $error("unidade_controle: address past the round limit");

endmodule

`default_nettype wire

// File: fluxo_dados.sv
`timescale 1ns/1ps
`default_nettype none

module fluxo_dados #(
    parameter int DISPLAY_CYCLES = 1000,
    parameter int TIMEOUT_CYCLES = 4000
) (
    input  wire                                  clock,
    input  wire                                  rst,
    input  wire                                  zera_e,
    input  wire                                  conta_e,
    input  wire                                  zera_l,
    input  wire                                  conta_l,
    input  wire                                  zera_m,
    input  wire                                  conta_m,
    input  wire                                  conta_t,
    input  wire                                  zera_r,
    input  wire                                  registra_r,
    input  wire                                  seleciona_memoria_r,
    input  wire jogo_memoria_pkg::seletor_leds_t seletor,
    input  wire  [jogo_memoria_pkg::data_w-1:0]  botoes,
    output logic                                 botoes_igual_memoria,
    output logic                                 fim_e,
    output logic                                 fim_l,
    output logic                                 fim_m,
    output logic                                 meio_m,
    output logic                                 endereco_igual_limite,
    output logic                                 jogada_feita,
    output logic                                 timeout,
    output logic [jogo_memoria_pkg::data_w-1:0]  leds,
    output logic [jogo_memoria_pkg::addr_w-1:0]  db_contagem,
    output logic [jogo_memoria_pkg::addr_w-1:0]  db_limite,
    output logic [jogo_memoria_pkg::data_w-1:0]  db_memoria,
    output logic [jogo_memoria_pkg::data_w-1:0]  db_jogada
);

    import jogo_memoria_pkg::*;

    logic [addr_w-1:0] endereco;
    logic [addr_w-1:0] limite;
    logic [data_w-1:0] dado_0;
    logic [data_w-1:0] dado_1;
    logic [data_w-1:0] memoria;
    logic [data_w-1:0] jogada;
    logic              fim_t;
    logic              algum_botao;
    logic              botao_ant;
    seletor_leds_t     seletor_q;

    // ----------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------

    contador_m #(.M(2**addr_w), .N(addr_w)) contador_endereco (
        .clock (clock),
        .rst   (rst),
        .zera  (zera_e),
        .conta (conta_e),
        .q     (endereco),
        .fim   (fim_e),
        .meio  ()
    );

    contador_m #(.M(n_rodadas), .N(addr_w)) contador_limite (
        .clock (clock),
        .rst   (rst),
        .zera  (zera_l),
        .conta (conta_l),
        .q     (limite),
        .fim   (fim_l),
        .meio  ()
    );

    // lit up to meio, dark up to fim
    contador_m #(.M(DISPLAY_CYCLES), .N($clog2(DISPLAY_CYCLES))) contador_mostra (
        .clock (clock),
        .rst   (rst),
        .zera  (zera_m),
        .conta (conta_m),
        .q     (),
        .fim   (fim_m),
        .meio  (meio_m)
    );

    // runs only while conta_t is high
    contador_m #(.M(TIMEOUT_CYCLES), .N($clog2(TIMEOUT_CYCLES))) contador_timeout (
        .clock (clock),
        .rst   (rst),
        .zera  (!conta_t),
        .conta (conta_t),
        .q     (),
        .fim   (fim_t),
        .meio  ()
    );

    // timeout flag, kept until the next game starts
    always_ff @(posedge clock) begin
        if (rst || zera_r) begin
            timeout <= 1'b0;
        end else if (conta_t && fim_t) begin
            timeout <= 1'b1;
        end
    end

    // ----------------------------------------------------------------
    // pattern memories
    // ----------------------------------------------------------------

    sync_rom_16x4 #(.TABELA(0)) rom_0 (
        .clock    (clock),
        .endereco (endereco),
        .dado     (dado_0)
    );

    sync_rom_16x4 #(.TABELA(1)) rom_1 (
        .clock    (clock),
        .endereco (endereco),
        .dado     (dado_1)
    );

    assign memoria = seleciona_memoria_r ? dado_1 : dado_0;

    // ----------------------------------------------------------------
    // play register, edge detector, compare
    // ----------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (rst || zera_r) begin
            jogada <= '0;
        end else if (registra_r) begin
            jogada <= botoes;
        end
    end

    assign algum_botao = |botoes;

    always_ff @(posedge clock) begin
        if (rst) begin
            botao_ant <= 1'b0;
        end else begin
            botao_ant <= algum_botao;
        end
    end

    // first cycle of a press only
    assign jogada_feita = algum_botao && !botao_ant;

    assign botoes_igual_memoria  = (jogada == memoria);
    assign endereco_igual_limite = (endereco == limite);

    // led source lags one cycle to line up with the rom read
    always_ff @(posedge clock) begin
        if (rst) begin
            seletor_q <= leds_apagados;
        end else begin
            seletor_q <= seletor;
        end
    end

    always_comb begin
        case (seletor_q)
            leds_memoria: leds = memoria;
            leds_botoes:  leds = botoes;
            default:      leds = '0;
        endcase
    end

    assign db_contagem = endereco;
    assign db_limite   = limite;
    assign db_memoria  = memoria;
    assign db_jogada   = jogada;

    a_jogada_um_ciclo: assert property (
        @(posedge clock) disable iff (rst)
        jogada_feita |=> !jogada_feita
    ) else $error("fluxo_dados: jogada_feita held for two cycles");

endmodule

`default_nettype wire

// File: sync_rom_16x4.sv
`timescale 1ns/1ps
`default_nettype none

module sync_rom_16x4 #(
    parameter int TABELA = 0
) (
    input  wire                                 clock,
    input  wire  [jogo_memoria_pkg::addr_w-1:0] endereco,
    output logic [jogo_memoria_pkg::data_w-1:0] dado
);

    import jogo_memoria_pkg::*;

    // table 0 walks the buttons upward, one per entry
    localparam logic [data_w-1:0] tabela_0 [2**addr_w] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0001, 4'b0010, 4'b0100, 4'b1000
    };

    // table 1 steps three buttons at a time
    localparam logic [data_w-1:0] tabela_1 [2**addr_w] = '{
        4'b0001, 4'b1000, 4'b0100, 4'b0010,
        4'b0001, 4'b1000, 4'b0100, 4'b0010,
        4'b0001, 4'b1000, 4'b0100, 4'b0010,
        4'b0001, 4'b1000, 4'b0100, 4'b0010
    };

    // registered read, data one cycle after the address
    always_ff @(posedge clock) begin
        if (TABELA == 0) begin
            dado <= tabela_0[endereco];
        end else begin
            dado <= tabela_1[endereco];
        end
    end

endmodule

`default_nettype wire

// File: contador_m.sv
`timescale 1ns/1ps
`default_nettype none

module contador_m #(
    parameter int M = 16,
    parameter int N = 4
) (
    input  wire          clock,
    input  wire          rst,
    input  wire          zera,
    input  wire          conta,
    output logic [N-1:0] q,
    output logic         fim,
    output logic         meio
);

    // clear wins over count
    always_ff @(posedge clock) begin
        if (rst || zera) begin
            q <= '0;
        end else if (conta) begin
            if (q == N'(M - 1)) begin
                q <= '0;
            end else begin
                q <= q + 1'b1;
            end
        end
    end

    // end of count and half-way flags
    assign fim  = (q == N'(M - 1));
    assign meio = (q == N'(M / 2 - 1));

    a_q_abaixo_de_m: assert property (
        @(posedge clock) disable iff (rst)
        q < M
    ) else $error("contador_m: q reached M");

endmodule

`default_nettype wire

// File: jogo_memoria_pkg.sv
`default_nettype none

package jogo_memoria_pkg;

    // button pattern and rom word width
    localparam int data_w = 4;

    // rom address width
    localparam int addr_w = 4;

    // rounds in a full game
    localparam int n_rodadas = 16;

    // control unit states, brought out on db_estado
    typedef enum logic [4:0] {
        inicial          = 5'h00,
        preparacao       = 5'h01,
        mostra           = 5'h02,
        mostra_intervalo = 5'h03,
        proximo_mostra   = 5'h04,
        espera_jogada    = 5'h05,
        registra         = 5'h06,
        comparacao       = 5'h07,
        proxima_jogada   = 5'h08,
        proxima_rodada   = 5'h09,
        fim_ganhou       = 5'h0a,
        fim_perdeu       = 5'h0b
    } estado_t;

    // led source select
    typedef enum logic [1:0] {
        leds_apagados = 2'b00,
        leds_memoria  = 2'b01,
        leds_botoes   = 2'b10
    } seletor_leds_t;

endpackage

`default_nettype wire
